// ==== test/branch_golden.txt ====
// issue instruction pc rs1_value rs2_value predicted_pc, then expected taken target_pc flush ras_push ras_pop
// All fields hex, one vector per line, issued back to back
1 00B50863 00001000 00000005 00000005 00001004 1 00001010 1 0 0
1 00B50863 00001000 FFFFFFF0 00000010 00001010 0 00001010 1 0 0
1 00B50863 00001000 00000010 FFFFFFF0 00001004 0 00001010 0 0 0
1 00B51863 00001000 00000005 00000005 00001004 0 00001010 0 0 0
1 00B51863 00001000 FFFFFFF0 00000010 00001010 1 00001010 0 0 0
1 00B51863 00001000 00000010 FFFFFFF0 00001004 1 00001010 1 0 0
1 FEB54CE3 00002000 00000005 00000005 00002004 0 00001FF8 0 0 0
1 FEB54CE3 00002000 FFFFFFF0 00000010 00001FF8 1 00001FF8 0 0 0
1 FEB54CE3 00002000 00000010 FFFFFFF0 00002004 0 00001FF8 0 0 0
1 FEB55CE3 00002000 00000005 00000005 00002004 1 00001FF8 1 0 0
1 FEB55CE3 00002000 FFFFFFF0 00000010 00001FF8 0 00001FF8 1 0 0
1 FEB55CE3 00002000 00000010 FFFFFFF0 00002004 1 00001FF8 1 0 0
1 00B560E3 00003000 00000005 00000005 00003004 0 00003800 0 0 0
1 00B560E3 00003000 FFFFFFF0 00000010 00003800 0 00003800 1 0 0
1 00B560E3 00003000 00000010 FFFFFFF0 00003004 1 00003800 1 0 0
1 00B570E3 00003000 00000005 00000005 00003004 1 00003800 1 0 0
1 00B570E3 00003000 FFFFFFF0 00000010 00003800 1 00003800 0 0 0
1 00B570E3 00003000 00000010 FFFFFFF0 00003004 0 00003800 0 0 0
1 100000EF 00004000 00000000 00000000 00004100 1 00004100 0 1 0
1 FE1FF06F 00005000 00000000 00000000 00005004 1 00004FE0 1 0 0
1 001002EF 00006000 00000000 00000000 00006800 1 00006800 0 1 0
1 003500E7 00007000 00008000 00000000 00008003 1 00008002 0 1 0
1 FFC50067 00007100 00009001 00000000 00007104 1 00008FFC 1 0 0
1 00008067 00004200 00004004 00000000 00004004 1 00004004 0 0 1
1 00008067 00006300 00006004 00000000 00004004 1 00006004 1 0 1
1 00028067 00006400 00006004 00000000 00006004 1 00006004 0 0 1
1 000080E7 0000B000 0000A000 00000000 0000B004 1 0000A000 1 1 0
1 00108093 00008000 00000001 00000002 00008004 0 00000000 0 0 0
0 100000EF 00004000 00000000 00000000 00004100 0 00000000 0 0 0

// ==== filelist.f ====
hdl/branch_cfg_pkg.sv
hdl/branch_types_pkg.sv
hdl/branch_ex_if.sv
hdl/branch_decode.sv
hdl/branch_execute.sv
hdl/branch_result.sv
hdl/branch_resolve_top.sv
test/branch_resolve_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the branch resolution testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module branch_resolve_tb -f filelist.f \
    --Mdir obj_dir -o branch_resolve_sim || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/branch_resolve_sim)"
echo "${sim_output}"
echo "${sim_output}" | grep -q "^TB PASSED$" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== test/branch_resolve_tb.sv ====
// Branch resolution testbench driving golden file vectors and then random conditional branches
`timescale 1ns/10ps
`default_nettype none

module branch_resolve_tb;

    localparam int    RANDOM_COUNT = 200;
    localparam string GOLDEN_FILE  = "test/branch_golden.txt";

    typedef struct packed {
        logic        issue;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] pred;
        logic        taken;
        logic [31:0] target;
        logic        flush;
        logic        push;
        logic        pop;
    } vector_t;

    logic        clk;
    logic        rst;
    logic        issue;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] predicted_pc;
    logic        resolve_valid;
    logic        taken;
    logic [31:0] target_pc;
    logic [31:0] link_pc;
    logic        flush;
    logic        ras_push;
    logic        ras_pop;
    logic [15:0] branch_miss_count;
    logic [15:0] return_miss_count;

    vector_t     vectors[$];
    vector_t     pending;
    vector_t     idle;
    vector_t     rand_vec;
    logic        have_pending = 1'b0;
    logic        loaded       = 1'b0;
    logic [31:0] rng_state    = 32'd94310;
    logic [31:0] branch_tally = '0;
    logic [31:0] return_tally = '0;
    int          error_count  = 0;

    branch_resolve_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .issue             (issue),
        .instruction       (instruction),
        .pc                (pc),
        .rs1_value         (rs1_value),
        .rs2_value         (rs2_value),
        .predicted_pc      (predicted_pc),
        .resolve_valid     (resolve_valid),
        .taken             (taken),
        .target_pc         (target_pc),
        .link_pc           (link_pc),
        .flush             (flush),
        .ras_push          (ras_push),
        .ras_pop           (ras_pop),
        .branch_miss_count (branch_miss_count),
        .return_miss_count (return_miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // JAL, JALR and the six defined branch encodings
    function automatic logic is_control(input logic [31:0] instr);
        logic [2:0] f3;
        f3 = instr[14:12];
        case (instr[6:0])
            7'b1101111, 7'b1100111: return 1'b1;
            7'b1100011:             return (f3 != 3'b010) && (f3 != 3'b011);
            default:                return 1'b0;
        endcase
    endfunction

    function automatic logic cond_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic draw(output logic [31:0] value);
        rng_state = lcg_next(rng_state);
        value     = rng_state;
    endtask

    // Random conditional branch with its expected resolution
    task automatic build_random(output vector_t v);
        logic [31:0] r;
        logic [12:0] imm;
        logic [2:0]  f3;
        logic [31:0] link;
        logic [31:0] actual;
        draw(r);
        case (r[31:28] % 4'd6)
            4'd0:    f3 = 3'b000;
            4'd1:    f3 = 3'b001;
            4'd2:    f3 = 3'b100;
            4'd3:    f3 = 3'b101;
            4'd4:    f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        draw(v.rs1);
        draw(r);
        // Equal, sign flipped or unrelated operands
        case (r[31:30])
            2'd0:    v.rs2 = v.rs1;
            2'd1:    v.rs2 = v.rs1 ^ 32'h8000_0000;
            default: v.rs2 = r;
        endcase
        draw(r);
        v.pc = {r[31:2], 2'b00};
        draw(r);
        imm     = {r[31:20], 1'b0};
        v.issue = 1'b1;
        v.instr = {imm[12], imm[10:5], 5'd12, 5'd11, f3, imm[4:1], imm[11], 7'b1100011};
        v.taken = cond_taken(f3, v.rs1, v.rs2);
        v.target = v.pc + {{19{imm[12]}}, imm};
        link    = v.pc + 32'd4;
        actual  = v.taken ? v.target : link;
        draw(r);
        v.pred  = r[31] ? v.target : link;
        v.flush = (actual[31:1] != v.pred[31:1]);
        v.push  = 1'b0;
        v.pop   = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Checking and driving
    //////////////////////////////////////////////////
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_result();
        logic exp_valid;
        exp_valid = pending.issue && is_control(pending.instr);
        check_value(32'(resolve_valid), 32'(exp_valid), "resolve_valid");
        check_value(32'(flush), 32'(exp_valid && pending.flush), "flush");
        check_value(32'(ras_push), 32'(exp_valid && pending.push), "ras_push");
        check_value(32'(ras_pop), 32'(exp_valid && pending.pop), "ras_pop");
        if (exp_valid) begin
            check_value(32'(taken), 32'(pending.taken), "taken");
            check_value(target_pc, pending.target, "target_pc");
            check_value(link_pc, pending.pc + 32'd4, "link_pc");
            if (pending.flush && pending.pop) begin
                return_tally = return_tally + 32'd1;
            end else if (pending.flush) begin
                branch_tally = branch_tally + 32'd1;
            end
        end
    endtask

    // Result of the previous issue is checked just before the next is driven
    task automatic apply_vector(input vector_t v);
        @(posedge clk);
        #1;
        if (have_pending) begin
            check_result();
        end
        issue        = v.issue;
        instruction  = v.instr;
        pc           = v.pc;
        rs1_value    = v.rs1;
        rs2_value    = v.rs2;
        predicted_pc = v.pred;
        pending      = v;
        have_pending = 1'b1;
    endtask

    task automatic load_golden();
        int          fd;
        int          fields;
        string       line;
        vector_t     v;
        logic [31:0] c [11];
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file %s", GOLDEN_FILE);
            error_count = error_count + 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "/") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", c[0], c[1],
                                     c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9], c[10]);
                    if (fields != 11) begin
                        $display("Golden file line has %0d fields instead of 11: %s",
                                 fields, line);
                        error_count = error_count + 1;
                    end else begin
                        v = {c[0][0], c[1], c[2], c[3], c[4], c[5], c[6][0], c[7],
                             c[8][0], c[9][0], c[10][0]};
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors.size() == 0) begin
            $display("The golden file gave no vectors to run");
            error_count = error_count + 1;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        rst          = 1'b1;
        // Mispredicted call held on the inputs through reset
        issue        = 1'b1;
        instruction  = 32'h100000EF;
        pc           = 32'h0000_4000;
        rs1_value    = '0;
        rs2_value    = '0;
        predicted_pc = 32'h0000_4004;
        idle         = '0;
        load_golden();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst   = 1'b0;
        issue = 1'b0;

        // Idle state straight out of reset
        check_value(32'(resolve_valid), 32'd0, "resolve_valid after reset");
        check_value(32'(flush), 32'd0, "flush after reset");
        check_value(32'(ras_push), 32'd0, "ras_push after reset");
        check_value(32'(ras_pop), 32'd0, "ras_pop after reset");
        check_value(32'(branch_miss_count), 32'd0, "branch_miss_count after reset");
        check_value(32'(return_miss_count), 32'd0, "return_miss_count after reset");

        foreach (vectors[i]) begin
            apply_vector(vectors[i]);
        end
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            build_random(rand_vec);
            apply_vector(rand_vec);
        end
        // Drain the last result and let the counters settle
        apply_vector(idle);
        apply_vector(idle);
        @(posedge clk);
        #1;
        check_value(32'(branch_miss_count), branch_tally, "branch_miss_count");
        check_value(32'(return_miss_count), return_tally, "return_miss_count");

        $display("Run complete: %0d errors, %0d branch misses, %0d return misses",
                 error_count, branch_tally, return_tally);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (loaded);
        repeat (vectors.size() + RANDOM_COUNT + 50) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 vectors.size() + RANDOM_COUNT + 50);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/branch_resolve_top.sv ====
// Branch resolution top: decode, execute register and result check
`timescale 1ns/10ps
`default_nettype none

module branch_resolve_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    issue,
    input  logic [31:0]                             instruction,
    input  logic [branch_cfg_pkg::XLEN-1:0]         pc,
    input  logic [branch_cfg_pkg::XLEN-1:0]         rs1_value,
    input  logic [branch_cfg_pkg::XLEN-1:0]         rs2_value,
    input  logic [branch_cfg_pkg::XLEN-1:0]         predicted_pc,
    output logic                                    resolve_valid,
    output logic                                    taken,
    output logic [branch_cfg_pkg::XLEN-1:0]         target_pc,
    output logic [branch_cfg_pkg::XLEN-1:0]         link_pc,
    output logic                                    flush,
    output logic                                    ras_push,
    output logic                                    ras_pop,
    output logic [branch_cfg_pkg::MISS_COUNT_W-1:0] branch_miss_count,
    output logic [branch_cfg_pkg::MISS_COUNT_W-1:0] return_miss_count
);

    branch_types_pkg::resolve_t resolved;

    // Decoded fields from decode to execute
    branch_ex_if ex_bus ();

    //////////////////////////////////////////////////
    // Pipeline
    //////////////////////////////////////////////////
    branch_decode i_decode (
        .instruction  (instruction),
        .pc           (pc),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .predicted_pc (predicted_pc),
        .issue        (issue),
        .dec          (ex_bus.dec)
    );

    branch_execute i_execute (
        .clk          (clk),
        .rst          (rst),
        .ex           (ex_bus.ex),
        .resolved     (resolved)
    );

    branch_result i_result (
        .clk               (clk),
        .rst               (rst),
        .resolved          (resolved),
        .flush             (flush),
        .ras_push          (ras_push),
        .ras_pop           (ras_pop),
        .branch_miss_count (branch_miss_count),
        .return_miss_count (return_miss_count)
    );

    // Result fields out to plain ports
    assign resolve_valid = resolved.valid;
    assign taken         = resolved.taken;
    assign target_pc     = resolved.target_pc;
    assign link_pc       = resolved.link_pc;

endmodule

`default_nettype wire

// ==== hdl/branch_result.sv ====
// Branch result: misprediction check, flush, return stack strobes and miss counters
`timescale 1ns/10ps
`default_nettype none

module branch_result (
    input  logic                                    clk,
    input  logic                                    rst,
    input  branch_types_pkg::resolve_t              resolved,
    output logic                                    flush,
    output logic                                    ras_push,
    output logic                                    ras_pop,
    output logic [branch_cfg_pkg::MISS_COUNT_W-1:0] branch_miss_count,
    output logic [branch_cfg_pkg::MISS_COUNT_W-1:0] return_miss_count
);

    logic [branch_cfg_pkg::XLEN-1:0]            actual_pc;
    logic                                       mispredict;
    logic [branch_cfg_pkg::MISS_COUNT_W-1:0]    branch_miss_q;
    logic [branch_cfg_pkg::MISS_COUNT_W-1:0]    return_miss_q;

    //////////////////////////////////////////////////
    // Misprediction
    //////////////////////////////////////////////////
    assign actual_pc = resolved.taken ? resolved.target_pc : resolved.link_pc;

    // Bit 0 never takes part in the compare
    assign mispredict = resolved.valid &&
        (actual_pc[branch_cfg_pkg::XLEN-1:1] !=
         resolved.predicted_pc[branch_cfg_pkg::XLEN-1:1]);

    // Without prediction fetch always assumes fall through
    assign flush = branch_cfg_pkg::USE_PREDICTION ? mispredict
                                                  : (resolved.valid && resolved.taken);

    // Return stack strobes
    assign ras_push = resolved.valid && resolved.is_call;
    assign ras_pop  = resolved.valid && resolved.is_return;

    //////////////////////////////////////////////////
    // Miss counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_miss_q <= '0;
            return_miss_q <= '0;
        end else if (mispredict) begin
            if (resolved.is_return) begin
                return_miss_q <= return_miss_q + 1'b1;
            end else begin
                branch_miss_q <= branch_miss_q + 1'b1;
            end
        end
    end

    assign branch_miss_count = branch_miss_q;
    assign return_miss_count = return_miss_q;

endmodule

`default_nettype wire

// ==== hdl/branch_execute.sv ====
// Branch execute stage: holds one decoded instruction and resolves taken
`timescale 1ns/10ps
`default_nettype none

module branch_execute (
    input  logic                        clk,
    input  logic                        rst,
    branch_ex_if.ex                     ex,
    output branch_types_pkg::resolve_t  resolved
);

    logic                               valid_q;
    branch_types_pkg::ctrl_kind_t       kind_q;
    logic                               cmp_q;
    logic [branch_cfg_pkg::XLEN-1:0]    target_q;
    logic [branch_cfg_pkg::XLEN-1:0]    link_q;
    logic [branch_cfg_pkg::XLEN-1:0]    predicted_q;
    logic                               call_q;
    logic                               return_q;
    logic                               taken;

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////
    // Valid follows the request every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ex.new_request;
        end
    end

    // Payload only loads on a request
    always_ff @(posedge clk) begin
        if (ex.new_request) begin
            kind_q      <= ex.kind;
            cmp_q       <= ex.cmp_result;
            target_q    <= ex.target_pc;
            link_q      <= ex.link_pc;
            predicted_q <= ex.predicted_pc;
            call_q      <= ex.is_call;
            return_q    <= ex.is_return;
        end
    end

    //////////////////////////////////////////////////
    // Taken
    //////////////////////////////////////////////////
    always_comb begin
        case (kind_q)
            branch_types_pkg::JAL,
            branch_types_pkg::JALR: taken = 1'b1;
            branch_types_pkg::COND: taken = cmp_q;
            default:                taken = 1'b0;
        endcase
    end

    always_comb begin
        resolved.valid        = valid_q;
        resolved.taken        = taken;
        resolved.target_pc    = target_q;
        resolved.link_pc      = link_q;
        resolved.predicted_pc = predicted_q;
        resolved.is_call      = call_q;
        resolved.is_return    = return_q;
    end

endmodule

`default_nettype wire

// ==== hdl/branch_decode.sv ====
// Branch decode: classifies the instruction, compares operands, forms target and link
`timescale 1ns/10ps
`default_nettype none

module branch_decode (
    input  logic [31:0]                         instruction,
    input  logic [branch_cfg_pkg::XLEN-1:0]     pc,
    input  logic [branch_cfg_pkg::XLEN-1:0]     rs1_value,
    input  logic [branch_cfg_pkg::XLEN-1:0]     rs2_value,
    input  logic [branch_cfg_pkg::XLEN-1:0]     predicted_pc,
    input  logic                                issue,
    branch_ex_if.dec                            dec
);

    logic [6:0]                         opcode;
    logic [2:0]                         funct3;
    logic [4:0]                         rd;
    logic [4:0]                         rs1_idx;
    logic [20:0]                        imm_j;
    logic [11:0]                        imm_i;
    logic [12:0]                        imm_b;
    logic [branch_cfg_pkg::XLEN-1:0]    offset;
    logic [branch_cfg_pkg::XLEN-1:0]    base;
    logic [branch_cfg_pkg::XLEN-1:0]    sum;
    logic signed [branch_cfg_pkg::XLEN:0] op_a;
    logic signed [branch_cfg_pkg::XLEN:0] op_b;
    logic                               less;
    logic                               equal;
    logic                               rd_link;
    logic                               rs1_link;
    branch_types_pkg::ctrl_kind_t       kind;

    assign opcode  = instruction[6:0];
    assign rd      = instruction[11:7];
    assign funct3  = instruction[14:12];
    assign rs1_idx = instruction[19:15];

    //////////////////////////////////////////////////
    // Classification
    //////////////////////////////////////////////////
    always_comb begin
        kind = branch_types_pkg::NONE;
        case (opcode)
            branch_cfg_pkg::OPC_JAL:    kind = branch_types_pkg::JAL;
            branch_cfg_pkg::OPC_JALR:   kind = branch_types_pkg::JALR;
            branch_cfg_pkg::OPC_BRANCH: begin
                // funct3 010 and 011 are reserved
                if (funct3[2:1] != 2'b01) begin
                    kind = branch_types_pkg::COND;
                end
            end
            default:                    kind = branch_types_pkg::NONE;
        endcase
    end

    //////////////////////////////////////////////////
    // Immediates and target
    //////////////////////////////////////////////////
    assign imm_j = {instruction[31], instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};
    assign imm_i = instruction[31:20];
    assign imm_b = {instruction[31], instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};

    always_comb begin
        case (kind)
            branch_types_pkg::JAL:  offset = {{(branch_cfg_pkg::XLEN-21){imm_j[20]}}, imm_j};
            branch_types_pkg::JALR: offset = {{(branch_cfg_pkg::XLEN-12){imm_i[11]}}, imm_i};
            default:                offset = {{(branch_cfg_pkg::XLEN-13){imm_b[12]}}, imm_b};
        endcase
    end

    // JALR is register relative, the rest pc relative
    assign base = (kind == branch_types_pkg::JALR) ? rs1_value : pc;
    assign sum  = base + offset;

    //////////////////////////////////////////////////
    // Comparator
    //////////////////////////////////////////////////
    // Extra top bit is the sign for BLT/BGE and zero for the unsigned pair
    assign op_a  = {~funct3[1] & rs1_value[branch_cfg_pkg::XLEN-1], rs1_value};
    assign op_b  = {~funct3[1] & rs2_value[branch_cfg_pkg::XLEN-1], rs2_value};
    assign less  = (op_a < op_b);
    assign equal = (rs1_value == rs2_value);

    // Stack hints
    assign rd_link  = (rd == branch_cfg_pkg::REG_RA) || (rd == branch_cfg_pkg::REG_T0);
    assign rs1_link = (rs1_idx == branch_cfg_pkg::REG_RA) || (rs1_idx == branch_cfg_pkg::REG_T0);

    // Outputs to execute
    assign dec.new_request  = issue && (kind != branch_types_pkg::NONE);
    assign dec.kind         = kind;
    assign dec.cmp_result   = (funct3[2] ? less : equal) ^ funct3[0];
    assign dec.target_pc    = {sum[branch_cfg_pkg::XLEN-1:1], 1'b0};
    assign dec.link_pc      = pc + branch_cfg_pkg::INSTR_BYTES;
    assign dec.predicted_pc = predicted_pc;
    assign dec.is_call      = ((kind == branch_types_pkg::JAL) ||
                               (kind == branch_types_pkg::JALR)) && rd_link;
    assign dec.is_return    = (kind == branch_types_pkg::JALR) && rs1_link && (rd == 5'd0);

endmodule

`default_nettype wire

// ==== hdl/branch_ex_if.sv ====
// Decode to execute bus carrying the decoded control transfer fields
`timescale 1ns/10ps
`default_nettype none

interface branch_ex_if;

    // Issue qualified by a kind other than NONE
    logic                               new_request;
    branch_types_pkg::ctrl_kind_t       kind;
    // Comparator output with the BNE, BGE and BGEU inversion applied
    logic                               cmp_result;
    logic [branch_cfg_pkg::XLEN-1:0]    target_pc;
    logic [branch_cfg_pkg::XLEN-1:0]    link_pc;
    logic [branch_cfg_pkg::XLEN-1:0]    predicted_pc;
    logic                               is_call;
    logic                               is_return;

    // Decode side
    modport dec (
        output new_request, kind, cmp_result,
        output target_pc, link_pc, predicted_pc,
        output is_call, is_return
    );

    // Execute side
    modport ex (
        input  new_request, kind, cmp_result,
        input  target_pc, link_pc, predicted_pc,
        input  is_call, is_return
    );

endinterface

`default_nettype wire

// ==== hdl/branch_types_pkg.sv ====
// Branch resolution types: instruction kind and the execute stage result
`default_nettype none

package branch_types_pkg;

    //////////////////////////////////////////////////
    // Instruction kind
    //////////////////////////////////////////////////

    // NONE marks anything that is not a control transfer
    typedef enum logic [1:0] {
        NONE = 2'd0,
        JAL  = 2'd1,
        JALR = 2'd2,
        COND = 2'd3
    } ctrl_kind_t;

    //////////////////////////////////////////////////
    // Execute stage result
    //////////////////////////////////////////////////

    typedef struct packed {
        // Set for one cycle per resolved instruction
        logic                               valid;
        logic                               taken;
        // Jump or branch destination, bit 0 already cleared
        logic [branch_cfg_pkg::XLEN-1:0]    target_pc;
        // Fall through address, pc plus 4
        logic [branch_cfg_pkg::XLEN-1:0]    link_pc;
        // Next pc that fetch went on with
        logic [branch_cfg_pkg::XLEN-1:0]    predicted_pc;
        // Return address stack hints
        logic                               is_call;
        logic                               is_return;
    } resolve_t;

endpackage

`default_nettype wire

// ==== hdl/branch_cfg_pkg.sv ====
// Branch resolution configuration: widths, RV32I opcodes and flush policy
`default_nettype none

package branch_cfg_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Major opcodes of the control transfer instructions
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Link registers ra and t0 per the calling convention hints
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // Size of one instruction, for the link address
    localparam logic [XLEN-1:0] INSTR_BYTES = 4;

    // 1: flush only on a wrong prediction, 0: flush on every taken transfer
    localparam bit USE_PREDICTION = 1'b1;

    // Width of both miss counters
    localparam int MISS_COUNT_W = 16;

endpackage

`default_nettype wire
